// File: design/dmaSystemPkg.sv
// DMA system shared types
`default_nettype none

package dmaSystemPkg;

    // data path widths
    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;
    // dma addresses and counts are full words
    localparam int byteAddrWidth = 32;

    // r-format funct codes handled by the alu
    localparam logic [5:0] functAdd = 6'd32;
    localparam logic [5:0] functSub = 6'd34;
    localparam logic [5:0] functAnd = 6'd36;
    localparam logic [5:0] functOr = 6'd37;

    // mips r-format instruction word
    typedef struct packed {
        logic [5:0] op;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rInstr_t;

    // memory word, seen whole or as byte lanes
    // lane 0 sits in bits 7..0
    typedef union packed {
        logic [wordWidth-1:0] word;
        logic [wordWidth/8-1:0][7:0] lanes;
    } memWord_t;

    // transfer request from the outside
    typedef struct packed {
        // 1 copies disk into ram, 0 copies ram into disk
        logic toRam;
        logic [byteAddrWidth-1:0] byteAddress;
        logic [byteAddrWidth-1:0] byteCount;
    } dmaDescriptor_t;

    // one byte moved on the bus
    typedef struct packed {
        logic valid;
        logic toRam;
        logic [byteAddrWidth-1:0] byteAddress;
        logic [7:0] value;
    } byteTransfer_t;

    // retired instruction result
    typedef struct packed {
        logic valid;
        logic [regAddrWidth-1:0] rd;
        logic [wordWidth-1:0] value;
    } commitRecord_t;

endpackage

`default_nettype wire

// File: design/registerFile.sv
// Core register file
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input wire logic clock,
    input wire logic reset,
    input wire logic [dmaSystemPkg::regAddrWidth-1:0] rsIndex,
    input wire logic [dmaSystemPkg::regAddrWidth-1:0] rtIndex,
    input wire logic regWrite,
    input wire logic [dmaSystemPkg::regAddrWidth-1:0] regWriteIndex,
    input wire logic [dmaSystemPkg::wordWidth-1:0] regWriteValue,
    output logic [dmaSystemPkg::wordWidth-1:0] rsValue,
    output logic [dmaSystemPkg::wordWidth-1:0] rtValue
);

    localparam int regCount = 2 ** dmaSystemPkg::regAddrWidth;

    logic [dmaSystemPkg::wordWidth-1:0] registers [regCount];

    // reset puts i in entry i
    // register 0 is an ordinary entry here
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                registers[i] <= dmaSystemPkg::wordWidth'(i);
            end
        end else if (regWrite) begin
            registers[regWriteIndex] <= regWriteValue;
        end
    end

    // two asynchronous read ports
    assign rsValue = registers[rsIndex];
    assign rtValue = registers[rtIndex];

endmodule

`default_nettype wire

// File: design/wordMemory.sv
// Byte-addressed word memory
`timescale 1ns/10ps
`default_nettype none

module wordMemory #(
    parameter int memWords = 32,
    parameter bit descendingFill = 1'b0
) (
    input wire logic clock,
    input wire logic reset,
    input wire logic [$clog2(memWords*4)-1:0] byteAddress,
    input wire logic byteWrite,
    input wire logic [7:0] writeByte,
    output logic [7:0] readByte
);

    localparam int memAddrWidth = $clog2(memWords * 4);

    dmaSystemPkg::memWord_t storage [memWords];
    logic [memAddrWidth-3:0] wordIndex;
    logic [1:0] laneIndex;

    // upper bits pick the word, low two the lane
    assign wordIndex = byteAddress[memAddrWidth-1:2];
    assign laneIndex = byteAddress[1:0];

    // reset fill, ram counts up and disk counts down
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < memWords; j++) begin
                if (descendingFill) begin
                    storage[j].word <= dmaSystemPkg::wordWidth'(memWords - 1 - j);
                end else begin
                    storage[j].word <= dmaSystemPkg::wordWidth'(j);
                end
            end
        end else if (byteWrite) begin
            // single lane written, rest of the word kept
            storage[wordIndex].lanes[laneIndex] <= writeByte;
        end
    end

    // combinational lane read
    assign readByte = storage[wordIndex].lanes[laneIndex];

endmodule

`default_nettype wire

// File: design/byteMover.sv
// DMA byte transfer engine
`timescale 1ns/10ps
`default_nettype none

module byteMover #(
    parameter int memWords = 32
) (
    input wire logic clock,
    input wire logic reset,
    input wire logic moveStart,
    input wire dmaSystemPkg::dmaDescriptor_t activeDescriptor,
    input wire logic [7:0] ramByte,
    input wire logic [7:0] diskByte,
    output logic [$clog2(memWords*4)-1:0] byteAddress,
    output logic ramWrite,
    output logic diskWrite,
    output logic [7:0] writeByte,
    output logic moveLast,
    output dmaSystemPkg::byteTransfer_t byteStrobe
);

    localparam int memBytes = memWords * 4;
    localparam int memAddrWidth = $clog2(memBytes);

    logic active;
    logic toRam;
    logic [memAddrWidth-1:0] address;
    logic [memAddrWidth-1:0] startAddress;
    logic [dmaSystemPkg::byteAddrWidth-1:0] remaining;
    logic [7:0] sourceByte;

    // start address folded into the memory
    assign startAddress = memAddrWidth'(activeDescriptor.byteAddress %
                          dmaSystemPkg::byteAddrWidth'(memBytes));

    // one byte per cycle while active
    always_ff @(posedge clock) begin
        if (reset) begin
            active <= 1'b0;
            toRam <= 1'b0;
            address <= '0;
            remaining <= '0;
        end else if (moveStart) begin
            active <= (activeDescriptor.byteCount != '0);
            toRam <= activeDescriptor.toRam;
            address <= startAddress;
            remaining <= activeDescriptor.byteCount;
        end else if (active) begin
            // wrap past the last byte
            if (address == memAddrWidth'(memBytes - 1)) begin
                address <= '0;
            end else begin
                address <= address + memAddrWidth'(1);
            end
            remaining <= remaining - dmaSystemPkg::byteAddrWidth'(1);
            active <= (remaining != dmaSystemPkg::byteAddrWidth'(1));
        end
    end

    // final byte on the bus now
    assign moveLast = active && (remaining == dmaSystemPkg::byteAddrWidth'(1));

    // both memories see the same byte address
    assign byteAddress = address;

    // source lane picked by direction
    assign sourceByte = toRam ? diskByte : ramByte;
    assign writeByte = sourceByte;
    assign ramWrite = active && toRam;
    assign diskWrite = active && !toRam;

    // strobe mirrors the byte written this edge
    always_comb begin
        byteStrobe.valid = active;
        byteStrobe.toRam = toRam;
        byteStrobe.byteAddress = dmaSystemPkg::byteAddrWidth'(address);
        byteStrobe.value = sourceByte;
    end

endmodule

`default_nettype wire

// File: design/busController.sv
// DMA bus arbitration FSM
`timescale 1ns/10ps
`default_nettype none

module busController (
    input wire logic clock,
    input wire logic reset,
    input wire logic dmaRequest,
    input wire dmaSystemPkg::dmaDescriptor_t dmaDescriptor,
    input wire logic holdAck,
    input wire logic moveLast,
    output logic holdRequest,
    output logic moveStart,
    output dmaSystemPkg::dmaDescriptor_t activeDescriptor,
    output logic dmaBusy,
    output logic dmaDone
);

    typedef enum logic [1:0] {
        stateIdle,
        stateRequesting,
        stateMoving,
        stateFinishing
    } busState_t;

    busState_t state;
    busState_t nextState;
    logic acceptRequest;

    // busy from latch until the done cycle
    assign dmaBusy = (state == stateRequesting) || (state == stateMoving);
    // hold the core exactly while busy
    assign holdRequest = dmaBusy;
    // done cycle also gives the bus back
    assign dmaDone = (state == stateFinishing);
    // mover kicked once the core lets go
    assign moveStart = (state == stateRequesting) && holdAck;

    // requests while busy are dropped
    assign acceptRequest = dmaRequest && !dmaBusy;

    always_comb begin
        nextState = state;
        case (state)
            stateIdle: begin
                if (acceptRequest) begin
                    nextState = stateRequesting;
                end
            end
            stateRequesting: begin
                // zero count skips the mover
                if (holdAck) begin
                    if (activeDescriptor.byteCount == '0) begin
                        nextState = stateFinishing;
                    end else begin
                        nextState = stateMoving;
                    end
                end
            end
            stateMoving: begin
                if (moveLast) begin
                    nextState = stateFinishing;
                end
            end
            stateFinishing: begin
                // a new request may land in the done cycle
                nextState = acceptRequest ? stateRequesting : stateIdle;
            end
            default: nextState = stateIdle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= stateIdle;
        end else begin
            state <= nextState;
        end
    end

    // descriptor captured on acceptance
    always_ff @(posedge clock) begin
        if (acceptRequest) begin
            activeDescriptor <= dmaDescriptor;
        end
    end

endmodule

`default_nettype wire

// File: design/cpuPipeline.sv
// Three-stage R-format core
`timescale 1ns/10ps
`default_nettype none

module cpuPipeline #(
    parameter int imemWords = 64
) (
    input wire logic clock,
    input wire logic reset,
    input wire logic progWrite,
    input wire logic [$clog2(imemWords)-1:0] progAddr,
    input wire dmaSystemPkg::rInstr_t progData,
    input wire logic holdRequest,
    input wire logic [dmaSystemPkg::wordWidth-1:0] rsValue,
    input wire logic [dmaSystemPkg::wordWidth-1:0] rtValue,
    output logic holdAck,
    output logic [dmaSystemPkg::regAddrWidth-1:0] rsIndex,
    output logic [dmaSystemPkg::regAddrWidth-1:0] rtIndex,
    output logic regWrite,
    output logic [dmaSystemPkg::regAddrWidth-1:0] regWriteIndex,
    output logic [dmaSystemPkg::wordWidth-1:0] regWriteValue,
    output dmaSystemPkg::commitRecord_t commit
);

    localparam int imemAddrWidth = $clog2(imemWords);
    // pc is a byte address, two extra low bits
    localparam int pcWidth = imemAddrWidth + 2;

    dmaSystemPkg::rInstr_t programMemory [imemWords];
    logic [pcWidth-1:0] pc;
    logic [pcWidth-1:0] pcNext;
    dmaSystemPkg::rInstr_t instrReg;
    logic instrValid;
    logic [dmaSystemPkg::wordWidth-1:0] aluResult;
    logic writesReg;
    logic exValid;
    logic [dmaSystemPkg::regAddrWidth-1:0] exRd;
    logic [dmaSystemPkg::wordWidth-1:0] exResult;
    logic freeze;

    // program load port, open in any cycle
    always_ff @(posedge clock) begin
        if (progWrite) begin
            programMemory[progAddr] <= progData;
        end
    end

    // bus handed over while the dma asks for it
    assign freeze = holdRequest;

    // ack follows the request by one edge
    always_ff @(posedge clock) begin
        if (reset) begin
            holdAck <= 1'b0;
        end else begin
            holdAck <= holdRequest;
        end
    end

    // wrap at the end of program memory
    assign pcNext = (pc[pcWidth-1:2] == imemAddrWidth'(imemWords - 1)) ?
                    '0 : pc + pcWidth'(4);

    // fetch stage
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
            instrValid <= 1'b0;
        end else if (!freeze) begin
            pc <= pcNext;
            instrValid <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!freeze) begin
            instrReg <= programMemory[pc[pcWidth-1:2]];
        end
    end

    // operands read in the execute cycle
    assign rsIndex = instrReg.rs;
    assign rtIndex = instrReg.rt;

    // alu, unknown funct gives zero
    always_comb begin
        case (instrReg.funct)
            dmaSystemPkg::functAdd: aluResult = rsValue + rtValue;
            dmaSystemPkg::functSub: aluResult = rsValue - rtValue;
            dmaSystemPkg::functAnd: aluResult = rsValue & rtValue;
            dmaSystemPkg::functOr: aluResult = rsValue | rtValue;
            default: aluResult = '0;
        endcase
    end

    // only plain r-format words write back
    assign writesReg = instrValid && (instrReg.op == '0) && (instrReg.shamt == '0);

    // execute stage
    always_ff @(posedge clock) begin
        if (reset) begin
            exValid <= 1'b0;
        end else if (!freeze) begin
            exValid <= writesReg;
        end
    end

    always_ff @(posedge clock) begin
        if (!freeze) begin
            exResult <= aluResult;
            exRd <= instrReg.rd;
        end
    end

    // writeback, register file written at the commit edge
    assign regWrite = exValid && !freeze;
    assign regWriteIndex = exRd;
    assign regWriteValue = exResult;

    // commit record, low through a freeze
    always_ff @(posedge clock) begin
        if (reset) begin
            commit <= '0;
        end else begin
            commit.valid <= regWrite;
            commit.rd <= exRd;
            commit.value <= exResult;
        end
    end

endmodule

`default_nettype wire

// File: design/dmaSystemTop.sv
// DMA bus-sharing system top
`timescale 1ns/10ps
`default_nettype none

module dmaSystemTop #(
    parameter int imemWords = 64,
    parameter int memWords = 32
) (
    input wire logic clock,
    input wire logic reset,
    input wire logic progWrite,
    input wire logic [$clog2(imemWords)-1:0] progAddr,
    input wire dmaSystemPkg::rInstr_t progData,
    input wire logic dmaRequest,
    input wire dmaSystemPkg::dmaDescriptor_t dmaDescriptor,
    output dmaSystemPkg::commitRecord_t commit,
    output dmaSystemPkg::byteTransfer_t byteStrobe,
    output logic busHeld,
    output logic dmaBusy,
    output logic dmaDone
);

    localparam int memAddrWidth = $clog2(memWords * 4);

    // core to register file
    logic [dmaSystemPkg::regAddrWidth-1:0] rsIndex;
    logic [dmaSystemPkg::regAddrWidth-1:0] rtIndex;
    logic [dmaSystemPkg::wordWidth-1:0] rsValue;
    logic [dmaSystemPkg::wordWidth-1:0] rtValue;
    logic regWrite;
    logic [dmaSystemPkg::regAddrWidth-1:0] regWriteIndex;
    logic [dmaSystemPkg::wordWidth-1:0] regWriteValue;

    // controller, mover and memories
    logic holdRequest;
    logic moveStart;
    logic moveLast;
    dmaSystemPkg::dmaDescriptor_t activeDescriptor;
    logic [memAddrWidth-1:0] byteAddress;
    logic ramWrite;
    logic diskWrite;
    logic [7:0] writeByte;
    logic [7:0] ramByte;
    logic [7:0] diskByte;

    // hold ack doubles as the bus-held flag
    cpuPipeline #(
        .imemWords(imemWords)
    ) i_cpuPipeline (
        .clock(clock),
        .reset(reset),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .holdRequest(holdRequest),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .holdAck(busHeld),
        .rsIndex(rsIndex),
        .rtIndex(rtIndex),
        .regWrite(regWrite),
        .regWriteIndex(regWriteIndex),
        .regWriteValue(regWriteValue),
        .commit(commit)
    );

    registerFile i_registerFile (
        .clock(clock),
        .reset(reset),
        .rsIndex(rsIndex),
        .rtIndex(rtIndex),
        .regWrite(regWrite),
        .regWriteIndex(regWriteIndex),
        .regWriteValue(regWriteValue),
        .rsValue(rsValue),
        .rtValue(rtValue)
    );

    busController i_busController (
        .clock(clock),
        .reset(reset),
        .dmaRequest(dmaRequest),
        .dmaDescriptor(dmaDescriptor),
        .holdAck(busHeld),
        .moveLast(moveLast),
        .holdRequest(holdRequest),
        .moveStart(moveStart),
        .activeDescriptor(activeDescriptor),
        .dmaBusy(dmaBusy),
        .dmaDone(dmaDone)
    );

    byteMover #(
        .memWords(memWords)
    ) i_byteMover (
        .clock(clock),
        .reset(reset),
        .moveStart(moveStart),
        .activeDescriptor(activeDescriptor),
        .ramByte(ramByte),
        .diskByte(diskByte),
        .byteAddress(byteAddress),
        .ramWrite(ramWrite),
        .diskWrite(diskWrite),
        .writeByte(writeByte),
        .moveLast(moveLast),
        .byteStrobe(byteStrobe)
    );

    // main memory, ascending fill
    wordMemory #(
        .memWords(memWords),
        .descendingFill(1'b0)
    ) ramMemory (
        .clock(clock),
        .reset(reset),
        .byteAddress(byteAddress),
        .byteWrite(ramWrite),
        .writeByte(writeByte),
        .readByte(ramByte)
    );

    // disk, descending fill
    wordMemory #(
        .memWords(memWords),
        .descendingFill(1'b1)
    ) diskMemory (
        .clock(clock),
        .reset(reset),
        .byteAddress(byteAddress),
        .byteWrite(diskWrite),
        .writeByte(writeByte),
        .readByte(diskByte)
    );

endmodule

`default_nettype wire

// File: verif/dmaSystemTb.sv
// DMA system directed testbench
`timescale 1ns/10ps
`default_nettype none

module dmaSystemTb;

    // short program so it loads inside the reset window
    localparam int progWords = 8;
    localparam int progAddrWidth = $clog2(progWords);
    localparam int memWords = 32;
    localparam int memBytes = memWords * 4;

    logic clock;
    logic reset;
    logic progWrite;
    logic [progAddrWidth-1:0] progAddr;
    dmaSystemPkg::rInstr_t progData;
    logic dmaRequest;
    dmaSystemPkg::dmaDescriptor_t dmaDescriptor;
    dmaSystemPkg::commitRecord_t commit;
    dmaSystemPkg::byteTransfer_t byteStrobe;
    logic busHeld;
    logic dmaBusy;
    logic dmaDone;

    // reference model of registers and both memories
    logic [31:0] modelRegs [32];
    logic [7:0] ramBytes [memBytes];
    logic [7:0] diskBytes [memBytes];
    int modelSlot;
    logic pendingValid;
    logic [4:0] pendingRd;
    logic [31:0] pendingValue;
    int skippedWords;

    // observed and expected bus traffic
    dmaSystemPkg::byteTransfer_t strobeQueue [$];
    dmaSystemPkg::byteTransfer_t expectedQueue [$];
    logic [7:0] lastValues [$];
    int commitCount;
    int doneCount;
    int cycleCount;

    int errorCount;
    int testCount;
    logic aborted;
    logic [31:0] lcgState;

    dmaSystemTop #(
        .imemWords(progWords),
        .memWords(memWords)
    ) i_dmaSystemTop (
        .clock(clock),
        .reset(reset),
        .progWrite(progWrite),
        .progAddr(progAddr),
        .progData(progData),
        .dmaRequest(dmaRequest),
        .dmaDescriptor(dmaDescriptor),
        .commit(commit),
        .byteStrobe(byteStrobe),
        .busHeld(busHeld),
        .dmaBusy(dmaBusy),
        .dmaDone(dmaDone)
    );

    // 8 ns clock
    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string message);
        if (actual !== expected) begin
            $display("ERROR at %0d ns: %s, got %0h expected %0h", $time, message, actual,
                     expected);
            errorCount++;
        end
    endtask

    task automatic timeoutFailure(input string what);
        $display("timeout: %s did not happen in time, remaining tests skipped", what);
        errorCount++;
        aborted = 1'b1;
    endtask

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // rd of slot i is read again two slots later
    // slot 3 unknown funct, slot 5 nonzero op, slot 6 nonzero shamt
    function automatic dmaSystemPkg::rInstr_t programWord(input int index);
        dmaSystemPkg::rInstr_t word;
        word = '0;
        word.rd = 5'(8 + index);
        word.rs = 5'(8 + (index + 6) % 8);
        word.rt = 5'(index);
        case (index % 4)
            0: word.funct = dmaSystemPkg::functAdd;
            1: word.funct = dmaSystemPkg::functSub;
            2: word.funct = dmaSystemPkg::functAnd;
            default: word.funct = dmaSystemPkg::functOr;
        endcase
        if (index == 3) begin
            word.funct = 6'd42;
        end
        if (index == 5) begin
            word.op = 6'd35;
        end
        if (index == 6) begin
            word.shamt = 5'd2;
        end
        return word;
    endfunction

    task automatic initModel();
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'(i);
        end
        // word j split into byte lanes, lane 0 lowest
        for (int j = 0; j < memWords; j++) begin
            for (int lane = 0; lane < 4; lane++) begin
                ramBytes[4 * j + lane] = 8'(j >> (8 * lane));
                diskBytes[4 * j + lane] = 8'((memWords - 1 - j) >> (8 * lane));
            end
        end
        modelSlot = 0;
        pendingValid = 1'b0;
        pendingRd = '0;
        pendingValue = '0;
        skippedWords = 0;
    endtask

    // step the program until the next word that writes back
    // previous slot's result is not yet visible when reading
    task automatic nextExpectedCommit(output logic [4:0] rd, output logic [31:0] value);
        dmaSystemPkg::rInstr_t instr;
        logic [31:0] result;
        logic found;
        found = 1'b0;
        rd = '0;
        value = '0;
        while (!found) begin
            instr = programWord(modelSlot);
            modelSlot = (modelSlot + 1) % progWords;
            case (instr.funct)
                dmaSystemPkg::functAdd: result = modelRegs[instr.rs] + modelRegs[instr.rt];
                dmaSystemPkg::functSub: result = modelRegs[instr.rs] - modelRegs[instr.rt];
                dmaSystemPkg::functAnd: result = modelRegs[instr.rs] & modelRegs[instr.rt];
                dmaSystemPkg::functOr: result = modelRegs[instr.rs] | modelRegs[instr.rt];
                default: result = '0;
            endcase
            if (pendingValid) begin
                modelRegs[pendingRd] = pendingValue;
            end
            if (instr.op == '0 && instr.shamt == '0) begin
                pendingValid = 1'b1;
                pendingRd = instr.rd;
                pendingValue = result;
                rd = instr.rd;
                value = result;
                found = 1'b1;
            end else begin
                pendingValid = 1'b0;
                skippedWords++;
            end
        end
    endtask

    // one clock, outputs sampled on the falling edge
    task automatic stepCycle();
        logic [4:0] expectedRd;
        logic [31:0] expectedValue;
        @(negedge clock);
        cycleCount++;
        if (commit.valid) begin
            // core is frozen while the dma owns the bus
            checkValue(32'(busHeld), 32'd0, "commit while bus held");
            nextExpectedCommit(expectedRd, expectedValue);
            checkValue(32'(commit.rd), 32'(expectedRd), "commit rd");
            checkValue(commit.value, expectedValue, "commit value");
            commitCount++;
        end
        if (byteStrobe.valid) begin
            checkValue(32'(busHeld), 32'd1, "byte strobe without bus held");
            strobeQueue.push_back(byteStrobe);
        end
        if (dmaDone) begin
            doneCount++;
        end
    endtask

    task automatic idleCycles(input int count);
        for (int n = 0; n < count; n++) begin
            stepCycle();
        end
    endtask

    task automatic waitForCommits(input int count);
        int target;
        int cycles;
        target = commitCount + count;
        cycles = 0;
        while (commitCount < target && cycles < count * 4 + 40) begin
            stepCycle();
            cycles++;
        end
        if (commitCount < target) begin
            timeoutFailure("commit stream");
        end
    endtask

    task automatic waitForDone(input int doneStart);
        int cycles;
        cycles = 0;
        while (doneCount == doneStart && cycles < 300) begin
            stepCycle();
            cycles++;
        end
        if (doneCount == doneStart) begin
            timeoutFailure("dmaDone");
        end
    endtask

    task automatic checkIdleOutputs(input string when);
        checkValue(32'(commit.valid), 32'd0, {"commit valid ", when});
        checkValue(32'(byteStrobe.valid), 32'd0, {"byte strobe ", when});
        checkValue(32'(busHeld), 32'd0, {"busHeld ", when});
        checkValue(32'(dmaBusy), 32'd0, {"dmaBusy ", when});
        checkValue(32'(dmaDone), 32'd0, {"dmaDone ", when});
    endtask

    // expected strobes, model memories updated as they go
    task automatic predictTransfer(input logic toRam, input logic [31:0] address,
                                   input logic [31:0] count);
        dmaSystemPkg::byteTransfer_t item;
        int location;
        expectedQueue.delete();
        for (int k = 0; k < int'(count); k++) begin
            // wraps over the whole memory
            location = int'((address + 32'(k)) % 32'(memBytes));
            item.valid = 1'b1;
            item.toRam = toRam;
            item.byteAddress = 32'(location);
            if (toRam) begin
                item.value = diskBytes[location];
                ramBytes[location] = item.value;
            end else begin
                item.value = ramBytes[location];
                diskBytes[location] = item.value;
            end
            expectedQueue.push_back(item);
        end
    endtask

    // one-cycle request pulse
    task automatic sendRequest(input logic toRam, input logic [31:0] address,
                               input logic [31:0] count);
        dmaRequest = 1'b1;
        dmaDescriptor.toRam = toRam;
        dmaDescriptor.byteAddress = address;
        dmaDescriptor.byteCount = count;
        stepCycle();
        dmaRequest = 1'b0;
    endtask

    task automatic checkTransfer(input int doneStart);
        waitForDone(doneStart);
        // quiet cycles to catch a stray done or strobe
        idleCycles(6);
        checkValue(32'(doneCount - doneStart), 32'd1, "dmaDone pulse count");
        checkValue(32'(strobeQueue.size()), 32'(expectedQueue.size()), "byte strobe count");
        lastValues.delete();
        for (int k = 0; k < strobeQueue.size() && k < expectedQueue.size(); k++) begin
            checkValue(strobeQueue[k].byteAddress, expectedQueue[k].byteAddress,
                       "strobe address");
            checkValue(32'(strobeQueue[k].value), 32'(expectedQueue[k].value), "strobe byte");
            checkValue(32'(strobeQueue[k].toRam), 32'(expectedQueue[k].toRam),
                       "strobe direction");
            lastValues.push_back(strobeQueue[k].value);
        end
        checkValue(32'(busHeld), 32'd0, "bus still held after done");
        checkValue(32'(dmaBusy), 32'd0, "dma still busy after done");
    endtask

    task automatic runTransfer(input logic toRam, input logic [31:0] address,
                               input logic [31:0] count);
        int doneStart;
        predictTransfer(toRam, address, count);
        strobeQueue.delete();
        doneStart = doneCount;
        sendRequest(toRam, address, count);
        checkTransfer(doneStart);
    endtask

    task automatic reportTest(input string name, input int startErrors);
        testCount++;
        $display("%s finished with %0d errors", name, errorCount - startErrors);
    endtask

    // reset for 10 cycles, program loaded meanwhile
    task automatic resetBehavior();
        int startErrors;
        startErrors = errorCount;
        for (int cycle = 0; cycle < 10; cycle++) begin
            @(negedge clock);
            checkIdleOutputs("during reset");
            if (cycle < progWords) begin
                progWrite = 1'b1;
                progAddr = progAddrWidth'(cycle);
                progData = programWord(cycle);
            end else begin
                progWrite = 1'b0;
            end
        end
        reset = 1'b0;
        // first fetch edge, nothing retired yet
        stepCycle();
        checkIdleOutputs("after reset");
        reportTest("reset", startErrors);
    endtask

    task automatic aluProgram();
        int startErrors;
        startErrors = errorCount;
        waitForCommits(24);
        reportTest("alu program", startErrors);
    endtask

    // twelve commits span exactly two program laps
    task automatic decodeRules();
        int startErrors;
        int cycleStart;
        int skippedStart;
        startErrors = errorCount;
        cycleStart = cycleCount;
        skippedStart = skippedWords;
        waitForCommits(12);
        // skipped words still take their slot, one word per cycle
        checkValue(32'(cycleCount - cycleStart), 32'(12 + skippedWords - skippedStart),
                   "cycles for two program laps");
        reportTest("decode rules", startErrors);
    endtask

    task automatic diskToRam();
        int startErrors;
        startErrors = errorCount;
        runTransfer(1'b1, 32'd2, 32'd16);
        // core picks up where it stopped
        waitForCommits(12);
        reportTest("disk to ram", startErrors);
    endtask

    task automatic ramToDiskReadback();
        int startErrors;
        logic [7:0] firstCopy [$];
        logic [31:0] randomValue;
        logic [31:0] address;
        logic [31:0] count;
        startErrors = errorCount;
        firstCopy = lastValues;
        runTransfer(1'b0, 32'd2, 32'd16);
        checkValue(32'(lastValues.size()), 32'(firstCopy.size()), "readback length");
        for (int k = 0; k < lastValues.size() && k < firstCopy.size(); k++) begin
            checkValue(32'(lastValues[k]), 32'(firstCopy[k]), "readback byte");
        end
        // across the top of memory
        runTransfer(1'b1, 32'd120, 32'd20);
        for (int n = 0; n < 4; n++) begin
            randomValue = nextRandom();
            address = nextRandom() % 32'd256;
            count = nextRandom() % 32'd40 + 32'd1;
            runTransfer(randomValue[16], address, count);
        end
        // zero count, done with no strobes
        runTransfer(1'b1, 32'd7, 32'd0);
        waitForCommits(6);
        reportTest("ram to disk and readback", startErrors);
    endtask

    task automatic busyRequest();
        int startErrors;
        int doneStart;
        startErrors = errorCount;
        predictTransfer(1'b1, 32'd40, 32'd6);
        strobeQueue.delete();
        doneStart = doneCount;
        sendRequest(1'b1, 32'd40, 32'd6);
        checkValue(32'(dmaBusy), 32'd1, "busy after request");
        // lands while busy, must vanish
        sendRequest(1'b0, 32'd100, 32'd9);
        checkTransfer(doneStart);
        waitForCommits(6);
        reportTest("busy request", startErrors);
    endtask

    initial begin
        reset = 1'b1;
        progWrite = 1'b0;
        progAddr = '0;
        progData = '0;
        dmaRequest = 1'b0;
        dmaDescriptor = '0;
        errorCount = 0;
        testCount = 0;
        aborted = 1'b0;
        commitCount = 0;
        doneCount = 0;
        cycleCount = 0;
        lcgState = 32'he030;
        initModel();
        resetBehavior();
        if (!aborted) begin
            aluProgram();
        end
        if (!aborted) begin
            decodeRules();
        end
        if (!aborted) begin
            diskToRam();
        end
        if (!aborted) begin
            ramToDiskReadback();
        end
        if (!aborted) begin
            busyRequest();
        end
        $display("summary: %0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
design/dmaSystemPkg.sv
design/registerFile.sv
design/wordMemory.sv
design/byteMover.sv
design/busController.sv
design/cpuPipeline.sv
design/dmaSystemTop.sv
verif/dmaSystemTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the DMA system testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f compile.f --top-module dmaSystemTb -o simDmaSystem; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simDmaSystem > sim.log 2>&1
simStatus=$?
cat sim.log
if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
